//--- verilog.f
hw/cpuPkg.sv
hw/progPkg.sv
hw/uopIf.sv
hw/progRom.sv
hw/regFile.sv
hw/execUnit.sv
hw/uopSequencer.sv
hw/fibCore.sv
dv/fibCoreTb.sv

//--- run.sh
#!/bin/sh
# Build and run the fibCore testbench with Verilator
set -e
cd "$(dirname "$0")"

logFile=sim.log
rm -rf obj_dir "$logFile"

verilator --binary --timing --assert \
	-f verilog.f \
	--top-module fibCoreTb \
	-o simFibCore

# The log decides pass or fail, not the exit status
./obj_dir/simFibCore > "$logFile" 2>&1 || true
cat "$logFile"

if grep -q "Simulation failed" "$logFile"; then
	exit 1
fi
grep -q "Simulation passed" "$logFile"

//--- dv/fibCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module fibCoreTb;

	localparam int clkPeriod   = 20;
	localparam int driveDelay  = 2;
	localparam int resetCycles = 10;
	localparam int stepCount   = 17;
	// Four cycles per step plus start and release slack
	localparam int runCycles   = stepCount * 4 + 3;
	localparam int maxGap      = 16;
	localparam int regCount    = 16;
	localparam int timeoutLimit = 2 * (resetCycles + 2 * runCycles + maxGap + 2 * regCount);

	logic        clk;
	logic        rst;
	logic        run;
	logic [3:0]  dbgAddr;
	logic [15:0] dbgData;
	logic        done;

	int cycleCount;
	int seed;
	int gap;

	// Each entry is {address, expected value}
	logic [19:0] expTable [16] = '{
		{4'd0,  16'd987}, {4'd1,  16'd1},   {4'd2,  16'd2},   {4'd3,  16'd3},
		{4'd4,  16'd5},   {4'd5,  16'd8},   {4'd6,  16'd13},  {4'd7,  16'd21},
		{4'd8,  16'd34},  {4'd9,  16'd55},  {4'd10, 16'd89},  {4'd11, 16'd144},
		{4'd12, 16'd233}, {4'd13, 16'd377}, {4'd14, 16'd610}, {4'd15, 16'd987}
	};

	fibCore dut0 (
		.clk     (clk),
		.rst     (rst),
		.run     (run),
		.dbgAddr (dbgAddr),
		.dbgData (dbgData),
		.done    (done)
	);

	//////////////////////////////////////////////////////////////////////
	// Clock and timeout
	//////////////////////////////////////////////////////////////////////

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	initial begin
		cycleCount = 0;
		while (cycleCount < timeoutLimit) begin
			@(posedge clk);
			cycleCount++;
		end
		failRun($sformatf("Timeout after %0d cycles", timeoutLimit));
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	task automatic failRun(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input int expected, input int actual);
		assert (actual == expected) else begin
			failRun($sformatf("[ERROR] %s: expected %0d, actual %0d", name, expected, actual));
		end
	endtask

	// Inputs change a little after the rising edge
	task automatic tick();
		@(posedge clk);
		#(driveDelay);
	endtask

	// Debug port is combinational, so a short settle is enough
	task automatic readReg(input logic [3:0] addr, output logic [15:0] data);
		dbgAddr = addr;
		#1;
		data = dbgData;
	endtask

	task automatic checkTable(input int runIdx);
		logic [15:0] data;
		logic [3:0]  addr;
		for (int i = 0; i < regCount; i++) begin
			tick();
			addr = expTable[i][19:16];
			readReg(addr, data);
			checkValue($sformatf("run %0d r%0d", runIdx, addr), int'(expTable[i][15:0]),
				int'(data));
		end
	endtask

	// Raises run and follows the program until done, checking along the way
	task automatic runProgram(input int runIdx);
		int          count;
		logic [15:0] data;
		logic [15:0] r1Prev;
		bit          r1Seen;
		count  = 0;
		r1Seen = 1'b0;
		r1Prev = '0;
		run    = 1'b1;
		do begin
			tick();
			count++;
			// Last step is still in its handshake through cycle 68
			if (count <= stepCount * 4) begin
				checkValue($sformatf("run %0d done low at cycle %0d", runIdx, count), 0,
					int'(done));
			end
			readReg(4'd15, data);
			if (runIdx == 1 && count < 60) begin
				checkValue("r15 mid-run", 0, int'(data));
			end
			// r1 is written once at step 1 and never again
			readReg(4'd1, data);
			if (count >= 8) begin
				if (r1Seen) begin
					checkValue("r1 repeat read", int'(r1Prev), int'(data));
				end
				checkValue("r1 after step 1", 1, int'(data));
				r1Prev = data;
				r1Seen = 1'b1;
			end
		end while (!done && count < runCycles);
		assert (done) else begin
			failRun($sformatf("done never came within %0d cycles of run %0d", runCycles, runIdx));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		logic [15:0] data;
		rst     = 1'b1;
		run     = 1'b0;
		dbgAddr = '0;
		seed    = 32'h152a;

		repeat (resetCycles) tick();
		rst = 1'b0;

		// Registers and done after reset
		tick();
		checkValue("done after reset", 0, int'(done));
		for (int i = 0; i < regCount; i++) begin
			readReg(4'(i), data);
			checkValue($sformatf("reset r%0d", i), 0, int'(data));
			tick();
		end

		runProgram(1);
		checkTable(1);

		// Rerun needs run low for at least one edge
		run = 1'b0;
		tick();
		gap = $random(seed) & 15;
		repeat (gap) begin
			tick();
			checkValue("done holds between runs", 1, int'(done));
		end

		runProgram(2);
		checkTable(2);

		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- hw/fibCore.sv
`timescale 1ns/1ps
`default_nettype none

module fibCore (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            run,
	input  logic [cpuPkg::regAddrWidth-1:0] dbgAddr,
	output logic [cpuPkg::dataWidth-1:0]    dbgData,
	output logic                            done
);
	import cpuPkg::*;

	logic                    we;
	logic [regAddrWidth-1:0] wAddr;
	logic [dataWidth-1:0]    wData;
	logic [regAddrWidth-1:0] rAddrA;
	logic [regAddrWidth-1:0] rAddrB;
	logic [dataWidth-1:0]    rDataA;
	logic [dataWidth-1:0]    rDataB;

	//////////////////////////////////////////////////////////////////////
	// Control path
	//////////////////////////////////////////////////////////////////////

	uopIf uop0 ();

	uopSequencer seq0 (
		.clk  (clk),
		.rst  (rst),
		.run  (run),
		.done (done),
		.uop  (uop0)
	);

	//////////////////////////////////////////////////////////////////////
	// Datapath
	//////////////////////////////////////////////////////////////////////

	execUnit exec0 (
		.clk    (clk),
		.rst    (rst),
		.uop    (uop0),
		.we     (we),
		.wAddr  (wAddr),
		.wData  (wData),
		.rAddrA (rAddrA),
		.rAddrB (rAddrB),
		.rDataA (rDataA),
		.rDataB (rDataB)
	);

	regFile rf0 (
		.clk     (clk),
		.rst     (rst),
		.we      (we),
		.wAddr   (wAddr),
		.wData   (wData),
		.rAddrA  (rAddrA),
		.rAddrB  (rAddrB),
		.rDataA  (rDataA),
		.rDataB  (rDataB),
		.dbgAddr (dbgAddr),
		.dbgData (dbgData)
	);

endmodule

`default_nettype wire

//--- hw/uopSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module uopSequencer (
	input  logic clk,
	input  logic rst,
	input  logic run,
	output logic done,
	uopIf.seq    uop
);
	import progPkg::*;

	seqState_t               state;
	logic [stepIdxWidth-1:0] stepIdx;
	logic [stepIdxWidth-1:0] nextIdx;
	progStep_t               romStep;
	logic                    runPrev;
	logic                    startRun;
	logic                    lastStep;
	logic                    issueNow;

	//////////////////////////////////////////////////////////////////////
	// Step fetch
	//////////////////////////////////////////////////////////////////////

	// ROM looks one step ahead so the fields are ready on entry to sIssue
	assign nextIdx = (state == sIdle || state == sDone) ? '0
		: stepIdx + stepIdxWidth'(1);

	progRom rom0 (
		.stepIdx (nextIdx),
		.step    (romStep)
	);

	// From sDone a rerun needs run to have dropped first
	assign startRun = run && ((state == sIdle) || (state == sDone && !runPrev));
	assign lastStep = (stepIdx == stepIdxWidth'(numSteps - 1));
	assign issueNow = startRun || (state == sWaitRel && !uop.ack && !lastStep);
	assign done     = (state == sDone);

	//////////////////////////////////////////////////////////////////////
	// Handshake FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= sIdle;
			stepIdx <= '0;
			uop.req <= 1'b0;
			runPrev <= 1'b0;
		end else begin
			runPrev <= run;
			if (issueNow) begin
				state   <= sIssue;
				stepIdx <= nextIdx;
				uop.req <= 1'b1;
			end else begin
				case (state)
					sIssue: state <= sWaitAck;
					sWaitAck: begin
						if (uop.ack) begin
							uop.req <= 1'b0;
							state   <= sWaitRel;
						end
					end
					// Only the last step gets here with ack low and no issue
					sWaitRel: if (!uop.ack) state <= sDone;
					default: state <= state;
				endcase
			end
		end
	end

	// Fields only change when a new step goes out
	always_ff @(posedge clk) begin
		if (issueNow) begin
			uop.op   <= romStep.op;
			uop.dest <= romStep.dest;
			uop.srcA <= romStep.srcA;
			uop.srcB <= romStep.srcB;
			uop.imm  <= romStep.imm;
		end
	end

	// Execution unit samples the fields until it acknowledges
	fieldsHeld: assert property (@(posedge clk) disable iff (rst)
		(uop.req && !uop.ack) |=> $stable({uop.op, uop.dest, uop.srcA, uop.srcB, uop.imm}))
		else $error("uop fields changed before ack");

endmodule

`default_nettype wire

//--- hw/execUnit.sv
`timescale 1ns/1ps
`default_nettype none

module execUnit (
	input  logic                            clk,
	input  logic                            rst,
	uopIf.exec                              uop,

	// Register file write port
	output logic                            we,
	output logic [cpuPkg::regAddrWidth-1:0] wAddr,
	output logic [cpuPkg::dataWidth-1:0]    wData,

	// Register file operand ports
	output logic [cpuPkg::regAddrWidth-1:0] rAddrA,
	output logic [cpuPkg::regAddrWidth-1:0] rAddrB,
	input  logic [cpuPkg::dataWidth-1:0]    rDataA,
	input  logic [cpuPkg::dataWidth-1:0]    rDataB
);
	import cpuPkg::*;

	logic newReq;

	// A request that is not yet acknowledged
	assign newReq = uop.req && !uop.ack;

	//////////////////////////////////////////////////////////////////////
	// Operand fetch and ALU
	//////////////////////////////////////////////////////////////////////

	assign rAddrA = uop.srcA;
	assign rAddrB = uop.srcB;

	always_comb begin
		case (uop.op)
			opLdi:   wData = uop.imm;
			// Carry out is dropped
			opAdd:   wData = rDataA + rDataB;
			opOr:    wData = rDataA | rDataB;
			default: wData = '0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Write and acknowledge
	//////////////////////////////////////////////////////////////////////

	// Write lands on the edge that also raises ack, so one pulse per request
	assign we    = newReq;
	assign wAddr = uop.dest;

	always_ff @(posedge clk) begin
		if (rst) begin
			uop.ack <= 1'b0;
		end else if (newReq) begin
			uop.ack <= 1'b1;
		end else if (!uop.req && uop.ack) begin
			// Release phase once the sequencer has let go of req
			uop.ack <= 1'b0;
		end
	end

	// The sequencer still holds req in the cycle where ack goes up
	ackAfterReq: assert property (@(posedge clk) disable iff (rst)
		$rose(uop.ack) |-> uop.req)
		else $error("ack rose without a pending req");

endmodule

`default_nettype wire

//--- hw/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input  logic                            clk,
	input  logic                            rst,

	// Write port
	input  logic                            we,
	input  logic [cpuPkg::regAddrWidth-1:0] wAddr,
	input  logic [cpuPkg::dataWidth-1:0]    wData,

	// Operand read ports
	input  logic [cpuPkg::regAddrWidth-1:0] rAddrA,
	input  logic [cpuPkg::regAddrWidth-1:0] rAddrB,
	output logic [cpuPkg::dataWidth-1:0]    rDataA,
	output logic [cpuPkg::dataWidth-1:0]    rDataB,

	// Host debug read port
	input  logic [cpuPkg::regAddrWidth-1:0] dbgAddr,
	output logic [cpuPkg::dataWidth-1:0]    dbgData
);
	import cpuPkg::*;

	logic [dataWidth-1:0] regs [numRegs];

	//////////////////////////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////////////////////////

	// All registers start at zero so a run begins from a known state
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wAddr] <= wData;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Reads
	//////////////////////////////////////////////////////////////////////

	// No bypass, a write shows up on the cycle after its edge
	assign rDataA  = regs[rAddrA];
	assign rDataB  = regs[rAddrB];

	// Same cycle as dbgAddr
	assign dbgData = regs[dbgAddr];

endmodule

`default_nettype wire

//--- hw/progRom.sv
`timescale 1ns/1ps
`default_nettype none

module progRom (
	input  logic [progPkg::stepIdxWidth-1:0] stepIdx,
	output progPkg::progStep_t               step
);
	import cpuPkg::*;
	import progPkg::*;

	//////////////////////////////////////////////////////////////////////
	// Fibonacci program
	//////////////////////////////////////////////////////////////////////

	// Fields are op, dest, srcA, srcB, imm
	always_comb begin
		case (stepIdx)
			// Seed the sequence
			5'd0:  step = '{opLdi, 4'd0,  4'd0,  4'd0,  16'd1};
			5'd1:  step = '{opLdi, 4'd1,  4'd0,  4'd0,  16'd1};

			// Each register is the sum of the two below it
			5'd2:  step = '{opAdd, 4'd2,  4'd1,  4'd0,  16'd0};
			5'd3:  step = '{opAdd, 4'd3,  4'd2,  4'd1,  16'd0};
			5'd4:  step = '{opAdd, 4'd4,  4'd3,  4'd2,  16'd0};
			5'd5:  step = '{opAdd, 4'd5,  4'd4,  4'd3,  16'd0};
			5'd6:  step = '{opAdd, 4'd6,  4'd5,  4'd4,  16'd0};
			5'd7:  step = '{opAdd, 4'd7,  4'd6,  4'd5,  16'd0};
			5'd8:  step = '{opAdd, 4'd8,  4'd7,  4'd6,  16'd0};
			5'd9:  step = '{opAdd, 4'd9,  4'd8,  4'd7,  16'd0};
			5'd10: step = '{opAdd, 4'd10, 4'd9,  4'd8,  16'd0};
			5'd11: step = '{opAdd, 4'd11, 4'd10, 4'd9,  16'd0};
			5'd12: step = '{opAdd, 4'd12, 4'd11, 4'd10, 16'd0};
			5'd13: step = '{opAdd, 4'd13, 4'd12, 4'd11, 16'd0};
			5'd14: step = '{opAdd, 4'd14, 4'd13, 4'd12, 16'd0};
			// r15 ends at 987
			5'd15: step = '{opAdd, 4'd15, 4'd14, 4'd13, 16'd0};

			// Copy the last term down into r0
			5'd16: step = '{opOr,  4'd0,  4'd15, 4'd15, 16'd0};

			// Past the end, rewrite r15 with itself so nothing changes
			default: begin
				step = '{opOr, 4'd15, 4'd15, 4'd15, 16'd0};
			end
		endcase
	end

endmodule

`default_nettype wire

//--- hw/uopIf.sv
`timescale 1ns/1ps
`default_nettype none

interface uopIf;
	import cpuPkg::*;

	// Micro-operation fields, stable while req is high
	aluOp_t                  op;
	logic [regAddrWidth-1:0] dest;
	logic [regAddrWidth-1:0] srcA;
	logic [regAddrWidth-1:0] srcB;
	logic [dataWidth-1:0]    imm;

	// Four-phase handshake pair
	logic req;
	logic ack;

	modport seq (
		output op, dest, srcA, srcB, imm, req,
		input  ack
	);

	modport exec (
		input  op, dest, srcA, srcB, imm, req,
		output ack
	);

endinterface

`default_nettype wire

//--- hw/progPkg.sv
`default_nettype none

package progPkg;

	//////////////////////////////////////////////////////////////////////
	// Program shape
	//////////////////////////////////////////////////////////////////////

	// Two loads, fourteen adds and the final copy into r0
	localparam int numSteps = 17;

	// Step counter width
	localparam int stepIdxWidth = $clog2(numSteps);

	// One stored micro-operation
	typedef struct packed {
		cpuPkg::aluOp_t                  op;
		logic [cpuPkg::regAddrWidth-1:0] dest;
		logic [cpuPkg::regAddrWidth-1:0] srcA;
		logic [cpuPkg::regAddrWidth-1:0] srcB;
		logic [cpuPkg::dataWidth-1:0]    imm;
	} progStep_t;

	//////////////////////////////////////////////////////////////////////
	// Sequencer FSM
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		// Waiting for run after reset
		sIdle,
		// req just raised with a fresh step
		sIssue,
		// Holding req until ack comes
		sWaitAck,
		// req dropped, waiting for ack to fall
		sWaitRel,
		// Program finished, done is high
		sDone
	} seqState_t;

endpackage

`default_nettype wire

//--- hw/cpuPkg.sv
`default_nettype none

package cpuPkg;

	//////////////////////////////////////////////////////////////////////
	// Datapath sizing
	//////////////////////////////////////////////////////////////////////

	// Register and ALU width
	localparam int dataWidth = 16;

	// Register file depth
	localparam int numRegs = 16;

	// Enough bits to name any register
	localparam int regAddrWidth = $clog2(numRegs);

	//////////////////////////////////////////////////////////////////////
	// ALU opcodes
	//////////////////////////////////////////////////////////////////////

	// Room for one more opcode before this has to grow
	localparam int aluOpWidth = 2;

	// Operands A and B come from the two read ports
	typedef enum logic [aluOpWidth-1:0] {
		// Destination takes the immediate
		opLdi = 2'd0,
		// Destination takes A plus B, wraps at dataWidth
		opAdd = 2'd1,
		// Destination takes A or B
		opOr  = 2'd2
	} aluOp_t;

endpackage

`default_nettype wire
